// ==== src/cu_pkg.sv ====
package cu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // micro-states
    // ~~~~~~~~~~~~~~~~~~~~
    // entry states carry their opcode value.
    typedef enum logic [5:0] {
        st_idle    = 6'd0,
        st_fetch1  = 6'd1,
        st_fetch2  = 6'd2,
        st_fetch3  = 6'd3,
        st_nop     = 6'd4,
        st_add1    = 6'd5,
        st_add2    = 6'd6,
        st_mul1    = 6'd7,
        st_mul2    = 6'd8,
        st_sub1    = 6'd9,
        st_sub2    = 6'd10,
        st_lodac1  = 6'd11,
        st_lodac2  = 6'd12,
        st_lodac3  = 6'd13,
        st_lodac4  = 6'd14,
        st_lodac5  = 6'd15,
        st_ldacar1 = 6'd16,
        st_ldacar2 = 6'd17,
        st_stoac1  = 6'd18,
        st_stoac2  = 6'd19,
        st_mvac    = 6'd20,
        st_movreg  = 6'd21,
        st_clac1   = 6'd22,
        st_clac2   = 6'd23,
        st_jump1   = 6'd24,
        st_jump2   = 6'd25,
        st_jump3   = 6'd26,
        st_jumpz   = 6'd27,
        st_jumpzn  = 6'd28,
        st_jmnz    = 6'd29,
        st_jmnzn   = 6'd30,
        st_incac   = 6'd31,
        st_incr    = 6'd32,
        st_incr3   = 6'd33,
        st_sftr1   = 6'd34,
        st_sftr2   = 6'd35,
        st_sftl1   = 6'd36,
        st_sftl2   = 6'd37,
        st_endop   = 6'd40
    } cu_state_t;

    typedef enum logic [1:0] {
        status_idle    = 2'b00,
        status_process = 2'b01    // starts a run.
    } cu_status_t;

    typedef enum logic [2:0] {
        alu_none = 3'd0,
        alu_add  = 3'd1,
        alu_mul  = 3'd2,
        alu_sub  = 3'd3,
        alu_sftr = 3'd4,
        alu_sftl = 3'd5,
        alu_zero = 3'd6
    } alu_op_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // bus sources
    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [4:0] {
        rd_none     = 5'd0,
        rd_ins_mem  = 5'd1,
        rd_data_mem = 5'd2,
        rd_pc       = 5'd3,
        rd_ir       = 5'd4,
        rd_ar       = 5'd5,
        rd_ac       = 5'd6,
        rd_x        = 5'd7,
        rd_y        = 5'd8,
        rd_z        = 5'd9,
        rd_stxy     = 5'd10,
        rd_styz     = 5'd11,
        rd_stxz     = 5'd12,
        rd_r        = 5'd13,
        rd_r1       = 5'd14,
        rd_r2       = 5'd15,
        rd_r3       = 5'd16,
        rd_dr       = 5'd17
    } read_src_t;

    localparam int WRITE_WIDTH = 17;

    localparam logic [WRITE_WIDTH-1:0] wr_data_mem = 17'h0_0001;
    localparam logic [WRITE_WIDTH-1:0] wr_alu_ac   = 17'h0_0002;
    localparam logic [WRITE_WIDTH-1:0] wr_ir_pc    = 17'h0_0004;
    localparam logic [WRITE_WIDTH-1:0] wr_ir       = 17'h0_0008;
    localparam logic [WRITE_WIDTH-1:0] wr_ar       = 17'h0_0010;
    localparam logic [WRITE_WIDTH-1:0] wr_x        = 17'h0_0020;
    localparam logic [WRITE_WIDTH-1:0] wr_y        = 17'h0_0040;
    localparam logic [WRITE_WIDTH-1:0] wr_z        = 17'h0_0080;
    localparam logic [WRITE_WIDTH-1:0] wr_stxy     = 17'h0_0100;
    localparam logic [WRITE_WIDTH-1:0] wr_styz     = 17'h0_0200;
    localparam logic [WRITE_WIDTH-1:0] wr_stxz     = 17'h0_0400;
    localparam logic [WRITE_WIDTH-1:0] wr_r        = 17'h0_0800;
    localparam logic [WRITE_WIDTH-1:0] wr_r1       = 17'h0_1000;
    localparam logic [WRITE_WIDTH-1:0] wr_r2       = 17'h0_2000;
    localparam logic [WRITE_WIDTH-1:0] wr_r3       = 17'h0_4000;
    localparam logic [WRITE_WIDTH-1:0] wr_dr       = 17'h0_8000;
    localparam logic [WRITE_WIDTH-1:0] wr_ac       = 17'h1_0000;

    localparam int INC_WIDTH = 7;

    // bits 2, 3 and 6 are spare.
    localparam logic [INC_WIDTH-1:0] inc_pc = 7'b000_0001;
    localparam logic [INC_WIDTH-1:0] inc_ac = 7'b000_0010;
    localparam logic [INC_WIDTH-1:0] inc_r  = 7'b001_0000;
    localparam logic [INC_WIDTH-1:0] inc_r3 = 7'b010_0000;

    typedef struct packed {
        logic [WRITE_WIDTH-1:0] write_enable;
        read_src_t              read_enable;
        logic [INC_WIDTH-1:0]   increment;
        alu_op_t                alu;
        logic                   finish;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_IDLE = '{
        write_enable: '0,
        read_enable:  rd_none,
        increment:    '0,
        alu:          alu_none,
        finish:       1'b0
    };

endpackage

// ==== src/micro_sequencer.sv ====
`timescale 1ns/100ps

module micro_sequencer #(
    parameter int INSTR_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   reset,
    input  cu_pkg::cu_status_t     status,
    input  logic                   z,
    input  logic [INSTR_WIDTH-1:0] instruction,
    output cu_pkg::cu_state_t      state
);

    logic [7:0]        opcode;
    cu_pkg::cu_state_t state_next;

    assign opcode = instruction[INSTR_WIDTH-1 -: 8];    // top byte.

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= cu_pkg::st_idle;
        else
            state <= state_next;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // next state
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        state_next = cu_pkg::st_fetch1;    // most states end here.
        case (state)
            cu_pkg::st_idle:
            begin
                if (status == cu_pkg::status_process)
                    state_next = cu_pkg::st_fetch1;
                else
                    state_next = cu_pkg::st_idle;
            end
            cu_pkg::st_fetch1:  state_next = cu_pkg::st_fetch2;
            cu_pkg::st_fetch2:  state_next = cu_pkg::st_fetch3;
            cu_pkg::st_fetch3:
            begin
                // opcode value is the entry state code.
                case (opcode)
                    8'(cu_pkg::st_nop),
                    8'(cu_pkg::st_add1),
                    8'(cu_pkg::st_mul1),
                    8'(cu_pkg::st_sub1),
                    8'(cu_pkg::st_lodac1),
                    8'(cu_pkg::st_ldacar1),
                    8'(cu_pkg::st_stoac1),
                    8'(cu_pkg::st_mvac),
                    8'(cu_pkg::st_movreg),
                    8'(cu_pkg::st_clac1),
                    8'(cu_pkg::st_jump1),
                    8'(cu_pkg::st_jumpz),
                    8'(cu_pkg::st_jmnz),
                    8'(cu_pkg::st_incac),
                    8'(cu_pkg::st_incr),
                    8'(cu_pkg::st_incr3),
                    8'(cu_pkg::st_sftr1),
                    8'(cu_pkg::st_sftl1),
                    8'(cu_pkg::st_endop):
                        state_next = cu_pkg::cu_state_t'(opcode[5:0]);
                    default:
                        state_next = cu_pkg::st_nop;    // unknown opcode.
                endcase
            end
            cu_pkg::st_add1:    state_next = cu_pkg::st_add2;
            cu_pkg::st_mul1:    state_next = cu_pkg::st_mul2;
            cu_pkg::st_sub1:    state_next = cu_pkg::st_sub2;
            cu_pkg::st_clac1:   state_next = cu_pkg::st_clac2;
            cu_pkg::st_sftr1:   state_next = cu_pkg::st_sftr2;
            cu_pkg::st_sftl1:   state_next = cu_pkg::st_sftl2;
            cu_pkg::st_lodac1:  state_next = cu_pkg::st_lodac2;
            cu_pkg::st_lodac2:  state_next = cu_pkg::st_lodac3;
            cu_pkg::st_lodac3:  state_next = cu_pkg::st_lodac4;
            cu_pkg::st_lodac4:  state_next = cu_pkg::st_lodac5;
            cu_pkg::st_ldacar1: state_next = cu_pkg::st_ldacar2;
            cu_pkg::st_stoac1:  state_next = cu_pkg::st_stoac2;
            cu_pkg::st_jump1:   state_next = cu_pkg::st_jump2;
            cu_pkg::st_jump2:   state_next = cu_pkg::st_jump3;
            cu_pkg::st_jumpz:
                state_next = z ? cu_pkg::st_jumpzn : cu_pkg::st_jump1;
            cu_pkg::st_jmnz:
                state_next = z ? cu_pkg::st_jump1 : cu_pkg::st_jmnzn;
            cu_pkg::st_endop:   state_next = cu_pkg::st_endop;    // held till reset.
            default:            state_next = cu_pkg::st_fetch1;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~
    state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {[cu_pkg::st_idle:cu_pkg::st_sftl2], cu_pkg::st_endop})
        else $error("undefined state code %0d", state);

    endop_holds: assert property (@(posedge clk) disable iff (reset)
        state == cu_pkg::st_endop |=> state == cu_pkg::st_endop)
        else $error("left ENDOP without reset");

    fetch_dispatches: assert property (@(posedge clk) disable iff (reset)
        state == cu_pkg::st_fetch3 |=> state != cu_pkg::st_idle)
        else $error("fetch fell back to IDLE");

endmodule

// ==== src/control_decode.sv ====
`timescale 1ns/100ps

module control_decode #(
    parameter int INSTR_WIDTH = 16
) (
    input  cu_pkg::cu_state_t      state,
    input  logic [INSTR_WIDTH-1:0] instruction,
    output cu_pkg::ctrl_word_t     ctrl
);

    logic [3:0] reg_sel;

    assign reg_sel = instruction[3:0];    // operand nibble.

    // ~~~~~~~~~~~~~~~~~~~~
    // register selector table
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic logic [cu_pkg::WRITE_WIDTH-1:0] sel_write(input logic [3:0] sel);
        case (sel)
            4'd1:    return cu_pkg::wr_x;
            4'd2:    return cu_pkg::wr_y;
            4'd3:    return cu_pkg::wr_z;
            4'd4:    return cu_pkg::wr_stxy;
            4'd5:    return cu_pkg::wr_styz;
            4'd6:    return cu_pkg::wr_stxz;
            4'd7:    return cu_pkg::wr_r;
            4'd8:    return cu_pkg::wr_r1;
            4'd9:    return cu_pkg::wr_r2;
            4'd10:   return cu_pkg::wr_r3;
            4'd11:   return cu_pkg::wr_dr;
            default: return '0;
        endcase
    endfunction

    function automatic cu_pkg::read_src_t sel_read(input logic [3:0] sel);
        case (sel)
            4'd1:    return cu_pkg::rd_x;
            4'd2:    return cu_pkg::rd_y;
            4'd3:    return cu_pkg::rd_z;
            4'd4:    return cu_pkg::rd_stxy;
            4'd5:    return cu_pkg::rd_styz;
            4'd6:    return cu_pkg::rd_stxz;
            4'd7:    return cu_pkg::rd_r;
            4'd8:    return cu_pkg::rd_r1;
            4'd9:    return cu_pkg::rd_r2;
            4'd10:   return cu_pkg::rd_r3;
            4'd11:   return cu_pkg::rd_dr;
            default: return cu_pkg::rd_none;
        endcase
    endfunction

    always_comb
    begin
        ctrl = cu_pkg::CTRL_IDLE;
        case (state)
            // ~~~~~~~~~~~~~~~~~~~~
            // fetch
            // ~~~~~~~~~~~~~~~~~~~~
            cu_pkg::st_fetch1:
                ctrl.read_enable = cu_pkg::rd_ins_mem;
            cu_pkg::st_fetch2:
            begin
                ctrl.read_enable  = cu_pkg::rd_ins_mem;
                ctrl.write_enable = cu_pkg::wr_ir;
            end
            cu_pkg::st_fetch3:
                ctrl.increment = cu_pkg::inc_pc;

            // ~~~~~~~~~~~~~~~~~~~~
            // alu
            // ~~~~~~~~~~~~~~~~~~~~
            cu_pkg::st_add1:
            begin
                ctrl.alu = cu_pkg::alu_add;
                case (reg_sel)
                    4'd1:    ctrl.read_enable = cu_pkg::rd_r;
                    4'd2:    ctrl.read_enable = cu_pkg::rd_r1;
                    4'd3:    ctrl.read_enable = cu_pkg::rd_r2;
                    default: ctrl.read_enable = cu_pkg::rd_none;
                endcase
            end
            cu_pkg::st_sub1:
            begin
                ctrl.alu         = cu_pkg::alu_sub;
                ctrl.read_enable = cu_pkg::rd_r;
            end
            cu_pkg::st_mul1:
            begin
                ctrl.alu         = cu_pkg::alu_mul;
                ctrl.read_enable = cu_pkg::rd_r1;
            end
            cu_pkg::st_clac1:   ctrl.alu = cu_pkg::alu_zero;
            cu_pkg::st_sftr1:   ctrl.alu = cu_pkg::alu_sftr;
            cu_pkg::st_sftl1:   ctrl.alu = cu_pkg::alu_sftl;
            cu_pkg::st_add2,
            cu_pkg::st_sub2,
            cu_pkg::st_mul2,
            cu_pkg::st_clac2,
            cu_pkg::st_sftr2,
            cu_pkg::st_sftl2:
                ctrl.write_enable = cu_pkg::wr_alu_ac;    // latch result.

            // ~~~~~~~~~~~~~~~~~~~~
            // memory
            // ~~~~~~~~~~~~~~~~~~~~
            cu_pkg::st_lodac1:
                ctrl.read_enable = cu_pkg::rd_ins_mem;    // address word.
            cu_pkg::st_lodac2:
            begin
                ctrl.read_enable  = cu_pkg::rd_ins_mem;
                ctrl.write_enable = cu_pkg::wr_ir;
            end
            cu_pkg::st_lodac3:
            begin
                ctrl.read_enable  = cu_pkg::rd_ir;
                ctrl.write_enable = cu_pkg::wr_ar;
                ctrl.increment    = cu_pkg::inc_pc;
            end
            cu_pkg::st_lodac4,
            cu_pkg::st_ldacar1:
            begin
                ctrl.read_enable  = cu_pkg::rd_data_mem;
                ctrl.write_enable = cu_pkg::wr_dr;
            end
            cu_pkg::st_lodac5,
            cu_pkg::st_ldacar2:
            begin
                ctrl.read_enable  = cu_pkg::rd_dr;
                ctrl.write_enable = cu_pkg::wr_ac;
            end
            cu_pkg::st_stoac1:
            begin
                ctrl.read_enable  = cu_pkg::rd_ac;
                ctrl.write_enable = cu_pkg::wr_dr;
            end
            cu_pkg::st_stoac2:
            begin
                ctrl.read_enable  = cu_pkg::rd_dr;
                ctrl.write_enable = cu_pkg::wr_data_mem;
            end

            // ~~~~~~~~~~~~~~~~~~~~
            // moves, jumps, misc
            // ~~~~~~~~~~~~~~~~~~~~
            cu_pkg::st_mvac:
            begin
                ctrl.read_enable  = cu_pkg::rd_ac;
                ctrl.write_enable = sel_write(reg_sel);
            end
            cu_pkg::st_movreg:
            begin
                ctrl.read_enable  = sel_read(reg_sel);
                ctrl.write_enable = cu_pkg::wr_ac;
            end
            cu_pkg::st_jump1:
                ctrl.read_enable = cu_pkg::rd_ins_mem;
            cu_pkg::st_jump2:
            begin
                ctrl.read_enable  = cu_pkg::rd_ins_mem;
                ctrl.write_enable = cu_pkg::wr_ir;
            end
            cu_pkg::st_jump3:
                ctrl.write_enable = cu_pkg::wr_ir_pc;    // target into pc.
            cu_pkg::st_jumpzn,
            cu_pkg::st_jmnzn:
                ctrl.increment = cu_pkg::inc_pc;    // skip target word.
            cu_pkg::st_incac:   ctrl.increment = cu_pkg::inc_ac;
            cu_pkg::st_incr:    ctrl.increment = cu_pkg::inc_r;
            cu_pkg::st_incr3:   ctrl.increment = cu_pkg::inc_r3;
            cu_pkg::st_endop:   ctrl.finish = 1'b1;
            default:            ctrl = cu_pkg::CTRL_IDLE;
        endcase
    end

endmodule

// ==== src/control_unit.sv ====
`timescale 1ns/100ps

module control_unit #(
    parameter int INSTR_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   reset,
    input  cu_pkg::cu_status_t     status,
    input  logic                   z,
    input  logic [INSTR_WIDTH-1:0] instruction,
    output cu_pkg::ctrl_word_t     ctrl
);

    cu_pkg::cu_state_t state;

    // ~~~~~~~~~~~~~~~~~~~~
    // sequencer and decoder
    // ~~~~~~~~~~~~~~~~~~~~
    micro_sequencer #(
        .INSTR_WIDTH (INSTR_WIDTH)
    ) u_seq (
        .clk         (clk),
        .reset       (reset),
        .status      (status),
        .z           (z),
        .instruction (instruction),
        .state       (state)
    );

    // ctrl follows the state and the operand nibble.
    control_decode #(
        .INSTR_WIDTH (INSTR_WIDTH)
    ) u_dec (
        .state       (state),
        .instruction (instruction),
        .ctrl        (ctrl)
    );

endmodule

// ==== bench/cu_tests.svh ====
task automatic idle_hold();
    int i;
    status = cu_pkg::status_idle;
    for (i = 0; i < 20; i++)
    begin
        @(negedge clk);
        check_word("idle_hold", cu_pkg::CTRL_IDLE);
        instruction = INSTR_WIDTH'($urandom);
        z = 1'($urandom);
    end
endtask

task automatic push_alu(input cu_pkg::alu_op_t alu, input cu_pkg::read_src_t rd);
    exp_q.push_back(alu_word(alu, rd));
    exp_q.push_back(rw_word(cu_pkg::wr_alu_ac, cu_pkg::rd_none));    // result into ac.
endtask

task automatic alu_ops();
    int i;
    logic [3:0] nib;
    status = cu_pkg::status_process;
    for (i = 0; i < 6; i++)
    begin
        nib = 4'($urandom % 4);
        push_alu(cu_pkg::alu_add, add_read(nib));
        run_instr("alu_ops add", op_add, nib, 1'b0);
    end
    push_alu(cu_pkg::alu_sub, cu_pkg::rd_r);
    run_instr("alu_ops sub", op_sub, 4'($urandom), 1'b0);
    push_alu(cu_pkg::alu_mul, cu_pkg::rd_r1);
    run_instr("alu_ops mul", op_mul, 4'($urandom), 1'b0);
    push_alu(cu_pkg::alu_zero, cu_pkg::rd_none);
    run_instr("alu_ops clac", op_clac, 4'($urandom), 1'b0);
    push_alu(cu_pkg::alu_sftr, cu_pkg::rd_none);
    run_instr("alu_ops sftr", op_sftr, 4'($urandom), 1'b0);
    push_alu(cu_pkg::alu_sftl, cu_pkg::rd_none);
    run_instr("alu_ops sftl", op_sftl, 4'($urandom), 1'b0);
endtask

task automatic reg_moves();
    int n;
    for (n = 0; n < 16; n++)
    begin
        exp_q.push_back(rw_word(wr_table[n], cu_pkg::rd_ac));
        run_instr("reg_moves mvac", op_mvac, 4'(n), 1'b0);
        exp_q.push_back(rw_word(cu_pkg::wr_ac, rd_table[n]));
        run_instr("reg_moves movreg", op_movreg, 4'(n), 1'b0);
    end
endtask

task automatic memory_ops();
    exp_q.push_back(rw_word('0, cu_pkg::rd_ins_mem));
    exp_q.push_back(rw_word(cu_pkg::wr_ir, cu_pkg::rd_ins_mem));
    exp_q.push_back(make_word(cu_pkg::wr_ar, cu_pkg::rd_ir, cu_pkg::inc_pc,
                              cu_pkg::alu_none, 1'b0));
    exp_q.push_back(rw_word(cu_pkg::wr_dr, cu_pkg::rd_data_mem));
    exp_q.push_back(rw_word(cu_pkg::wr_ac, cu_pkg::rd_dr));
    run_instr("memory_ops lodac", op_lodac, 4'($urandom), 1'b0);
    exp_q.push_back(rw_word(cu_pkg::wr_dr, cu_pkg::rd_data_mem));
    exp_q.push_back(rw_word(cu_pkg::wr_ac, cu_pkg::rd_dr));
    run_instr("memory_ops ldacar", op_ldacar, 4'($urandom), 1'b0);
    exp_q.push_back(rw_word(cu_pkg::wr_dr, cu_pkg::rd_ac));
    exp_q.push_back(rw_word(cu_pkg::wr_data_mem, cu_pkg::rd_dr));
    run_instr("memory_ops stoac", op_stoac, 4'($urandom), 1'b0);
endtask

task automatic branches_and_incs();
    int i;
    logic flip;
    logic zv;
    push_jump();
    run_instr("branches jump", op_jump, 4'($urandom), 1'($urandom));
    flip = 1'($urandom);    // random order of the two z values.
    for (i = 0; i < 2; i++)
    begin
        zv = 1'(i) ^ flip;
        exp_q.push_back(cu_pkg::CTRL_IDLE);    // test cycle.
        if (zv)
            exp_q.push_back(inc_word(cu_pkg::inc_pc));
        else
            push_jump();
        run_instr("branches jumpz", op_jumpz, 4'($urandom), zv);
        exp_q.push_back(cu_pkg::CTRL_IDLE);
        if (zv)
            push_jump();
        else
            exp_q.push_back(inc_word(cu_pkg::inc_pc));
        run_instr("branches jmnz", op_jmnz, 4'($urandom), zv);
    end
    exp_q.push_back(inc_word(cu_pkg::inc_ac));
    run_instr("branches incac", op_incac, 4'($urandom), 1'b0);
    exp_q.push_back(inc_word(cu_pkg::inc_r));
    run_instr("branches incr", op_incr, 4'($urandom), 1'b0);
    exp_q.push_back(inc_word(cu_pkg::inc_r3));
    run_instr("branches incr3", op_incr3, 4'($urandom), 1'b0);
    exp_q.push_back(cu_pkg::CTRL_IDLE);
    run_instr("branches nop", op_nop, 4'($urandom), 1'b0);
    exp_q.push_back(cu_pkg::CTRL_IDLE);
    run_instr("branches undefined 0x00", 8'h00, 4'($urandom), 1'b0);
    exp_q.push_back(cu_pkg::CTRL_IDLE);
    run_instr("branches undefined 0x26", 8'h26, 4'($urandom), 1'b0);
    exp_q.push_back(cu_pkg::CTRL_IDLE);    // low bits alias ADD.
    run_instr("branches undefined 0xc5", 8'hc5, 4'($urandom), 1'b0);
endtask

task automatic end_hold();
    int i;
    logic found;
    status = cu_pkg::status_process;
    wait_state(cu_pkg::st_fetch1, "end_hold", found);
    if (found)
    begin
        fetch_steps("end_hold", make_instr(op_endop, 4'($urandom)), 1'b0);
        for (i = 0; i < 30; i++)
        begin
            @(negedge clk);
            check_word("end_hold", make_word('0, cu_pkg::rd_none, '0, cu_pkg::alu_none, 1'b1));
            instruction = INSTR_WIDTH'($urandom);
            z = 1'($urandom);
        end
    end
    status = cu_pkg::status_idle;
    apply_reset(16);
    for (i = 0; i < 3; i++)
    begin
        check_word("end_hold after reset", cu_pkg::CTRL_IDLE);
        @(negedge clk);
    end
endtask

// ==== bench/control_unit_tb.sv ====
`timescale 1ns/100ps

module control_unit_tb;

    localparam int INSTR_WIDTH = 16;
    localparam int wait_limit  = 50;    // cycles per state wait.

    localparam logic [7:0] op_nop    = 8'd4;
    localparam logic [7:0] op_add    = 8'd5;
    localparam logic [7:0] op_mul    = 8'd7;
    localparam logic [7:0] op_sub    = 8'd9;
    localparam logic [7:0] op_lodac  = 8'd11;
    localparam logic [7:0] op_ldacar = 8'd16;
    localparam logic [7:0] op_stoac  = 8'd18;
    localparam logic [7:0] op_mvac   = 8'd20;
    localparam logic [7:0] op_movreg = 8'd21;
    localparam logic [7:0] op_clac   = 8'd22;
    localparam logic [7:0] op_jump   = 8'd24;
    localparam logic [7:0] op_jumpz  = 8'd27;
    localparam logic [7:0] op_jmnz   = 8'd29;
    localparam logic [7:0] op_incac  = 8'd31;
    localparam logic [7:0] op_incr   = 8'd32;
    localparam logic [7:0] op_incr3  = 8'd33;
    localparam logic [7:0] op_sftr   = 8'd34;
    localparam logic [7:0] op_sftl   = 8'd36;
    localparam logic [7:0] op_endop  = 8'd40;

    logic                   clk;
    logic                   reset;
    cu_pkg::cu_status_t     status;
    logic                   z;
    logic [INSTR_WIDTH-1:0] instruction;
    cu_pkg::ctrl_word_t     ctrl;

    int                     errors;
    int                     timeouts;
    cu_pkg::ctrl_word_t     exp_q [$];    // execute words of the next instruction.
    logic [cu_pkg::WRITE_WIDTH-1:0] wr_table [16];
    cu_pkg::read_src_t      rd_table [16];

    control_unit #(
        .INSTR_WIDTH (INSTR_WIDTH)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .status      (status),
        .z           (z),
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~
    // expected words
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic cu_pkg::ctrl_word_t make_word(
        input logic [cu_pkg::WRITE_WIDTH-1:0] wr,
        input cu_pkg::read_src_t              rd,
        input logic [cu_pkg::INC_WIDTH-1:0]   inc,
        input cu_pkg::alu_op_t                alu,
        input logic                           fin
    );
        cu_pkg::ctrl_word_t w;
        w.write_enable = wr;
        w.read_enable  = rd;
        w.increment    = inc;
        w.alu          = alu;
        w.finish       = fin;
        return w;
    endfunction

    function automatic cu_pkg::ctrl_word_t rw_word(
        input logic [cu_pkg::WRITE_WIDTH-1:0] wr,
        input cu_pkg::read_src_t              rd
    );
        return make_word(wr, rd, '0, cu_pkg::alu_none, 1'b0);
    endfunction

    function automatic cu_pkg::ctrl_word_t inc_word(input logic [cu_pkg::INC_WIDTH-1:0] inc);
        return make_word('0, cu_pkg::rd_none, inc, cu_pkg::alu_none, 1'b0);
    endfunction

    function automatic cu_pkg::ctrl_word_t alu_word(
        input cu_pkg::alu_op_t   alu,
        input cu_pkg::read_src_t rd
    );
        return make_word('0, rd, '0, alu, 1'b0);
    endfunction

    function automatic cu_pkg::read_src_t add_read(input logic [3:0] nib);
        if (nib == 4'd1)
            return cu_pkg::rd_r;
        else if (nib == 4'd2)
            return cu_pkg::rd_r1;
        else if (nib == 4'd3)
            return cu_pkg::rd_r2;
        return cu_pkg::rd_none;
    endfunction

    // opcode in the top byte, selector in the low nibble, the rest random.
    function automatic logic [INSTR_WIDTH-1:0] make_instr(input logic [7:0] op,
                                                          input logic [3:0] nib);
        logic [INSTR_WIDTH-1:0] w;
        w = INSTR_WIDTH'($urandom);
        w[INSTR_WIDTH-1 -: 8] = op;
        w[3:0] = nib;
        return w;
    endfunction

    task automatic fill_tables();
        int n;
        for (n = 0; n < 16; n++)
        begin
            wr_table[n] = '0;
            rd_table[n] = cu_pkg::rd_none;
        end
        wr_table[1]  = cu_pkg::wr_x;
        wr_table[2]  = cu_pkg::wr_y;
        wr_table[3]  = cu_pkg::wr_z;
        wr_table[4]  = cu_pkg::wr_stxy;
        wr_table[5]  = cu_pkg::wr_styz;
        wr_table[6]  = cu_pkg::wr_stxz;
        wr_table[7]  = cu_pkg::wr_r;
        wr_table[8]  = cu_pkg::wr_r1;
        wr_table[9]  = cu_pkg::wr_r2;
        wr_table[10] = cu_pkg::wr_r3;
        wr_table[11] = cu_pkg::wr_dr;
        rd_table[1]  = cu_pkg::rd_x;
        rd_table[2]  = cu_pkg::rd_y;
        rd_table[3]  = cu_pkg::rd_z;
        rd_table[4]  = cu_pkg::rd_stxy;
        rd_table[5]  = cu_pkg::rd_styz;
        rd_table[6]  = cu_pkg::rd_stxz;
        rd_table[7]  = cu_pkg::rd_r;
        rd_table[8]  = cu_pkg::rd_r1;
        rd_table[9]  = cu_pkg::rd_r2;
        rd_table[10] = cu_pkg::rd_r3;
        rd_table[11] = cu_pkg::rd_dr;
    endtask

    task automatic push_jump();
        exp_q.push_back(rw_word('0, cu_pkg::rd_ins_mem));
        exp_q.push_back(rw_word(cu_pkg::wr_ir, cu_pkg::rd_ins_mem));
        exp_q.push_back(rw_word(cu_pkg::wr_ir_pc, cu_pkg::rd_none));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // drive and check
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic check_word(input string name, input cu_pkg::ctrl_word_t expected);
        assert (ctrl === expected)
        else
        begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, ctrl);
        end
    endtask

    task automatic apply_reset(input int cycles);
        reset = 1'b1;
        repeat (cycles) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic wait_state(input cu_pkg::cu_state_t target, input string name,
                              output logic found);
        int n;
        n = 0;
        while (UUT.state != target && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        found = (UUT.state == target);
        if (!found)
        begin
            timeouts++;
            $display("%s: timed out waiting for state %0d", name, target);
        end
    endtask

    // starts at a falling edge inside FETCH1.
    task automatic fetch_steps(input string name, input logic [INSTR_WIDTH-1:0] instr,
                               input logic zv);
        check_word(name, rw_word('0, cu_pkg::rd_ins_mem));
        instruction = instr;
        z = zv;
        @(negedge clk);
        check_word(name, rw_word(cu_pkg::wr_ir, cu_pkg::rd_ins_mem));
        @(negedge clk);
        check_word(name, inc_word(cu_pkg::inc_pc));
    endtask

    task automatic run_instr(input string name, input logic [7:0] op,
                             input logic [3:0] nib, input logic zv);
        logic found;
        wait_state(cu_pkg::st_fetch1, name, found);
        if (found)
        begin
            fetch_steps(name, make_instr(op, nib), zv);
            foreach (exp_q[i])
            begin
                @(negedge clk);
                check_word(name, exp_q[i]);
            end
            @(negedge clk);
            check_word(name, rw_word('0, cu_pkg::rd_ins_mem));    // back in fetch1.
        end
        exp_q.delete();
    endtask

    `include "cu_tests.svh"

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        status      = cu_pkg::status_idle;
        z           = 1'b0;
        instruction = '0;
        errors      = 0;
        timeouts    = 0;
        void'($urandom(32'h924e));
        fill_tables();
        apply_reset(16);

        idle_hold();
        alu_ops();
        reg_moves();
        memory_ops();
        branches_and_incs();
        end_hold();

        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== control_unit.f ====
+incdir+bench
src/cu_pkg.sv
src/micro_sequencer.sv
src/control_decode.sv
src/control_unit.sv
bench/control_unit_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module control_unit_tb \
		-f control_unit.f -Mdir obj_dir
	./obj_dir/Vcontrol_unit_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
